//--- Makefile
# Verilator flow for the debug bus module

VERILATOR ?= verilator
FLIST     ?= sources.f
TOP       ?= dbg_bus_module_tb
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim
VFLAGS    ?= --timing
PASS_MSG  ?= All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(SIM_BIN)
	@out="$$(./$(BUILD_DIR)/$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- design/dbg_burst_ctrl.sv
/*
  Burst controller
  FSM for burst reads and writes with the bit, word and address counters.
  Launches bus transfers and steers the CRC and the TDO path
*/
`timescale 1ns/100ps

module dbg_burst_ctrl #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32,
  parameter int DR_LEN     = dbg_bus_pkg::DR_LEN
) (
  input  logic                   dbg_clk,
  input  logic                   dbg_rst,
  input  logic                   dbg_tdi_i,
  input  logic                   capture_dr_i,
  input  logic                   shift_dr_i,
  input  logic                   update_dr_i,
  input  logic                   module_select_i,
  input  dbg_bus_pkg::dbg_dr_u   data_register_i,
  input  logic                   burst_rd_i,
  input  logic                   burst_wr_i,
  input  logic                   ireg_wr_i,
  input  logic                   module_cmd_i,
  input  dbg_bus_pkg::word_cfg_t cfg_i,
  input  logic                   biu_rdy_i,
  input  logic                   crc_match_i,
  output logic                   op_ld_o,
  output dbg_bus_pkg::tdo_ctrl_t ctrl_o,
  output dbg_bus_pkg::bus_req_t  bus_req_o,
  output logic                   inhibit_o
);
  import dbg_bus_pkg::*;

  burst_state_e          state_q;
  burst_state_e          state_d;
  logic [ADDR_WIDTH-1:0] addr_q;      // Address of next transfer
  logic [5:0]            bit_cnt_q;   // Bits moved in current word
  logic [15:0]           word_cnt_q;  // Words left
  logic                  addr_ld;
  logic                  addr_inc;
  logic                  bit_clr;
  logic                  bit_inc;
  logic                  word_ld;
  logic                  word_dec;
  logic                  strb;
  logic                  clr_err;
  logic                  load_word;   // Take read data and launch the next read
  logic                  cmd_upd;
  logic                  word_zero;
  logic                  more_words;
  logic                  bit_max;
  logic                  bit_32;

  assign cmd_upd    = module_select_i & module_cmd_i & update_dr_i;
  assign word_zero  = (word_cnt_q == 16'd0);
  assign more_words = (word_cnt_q > 16'd1);
  assign bit_max    = (bit_cnt_q == cfg_i.size_bits_m1);
  assign bit_32     = (bit_cnt_q == 6'd32);

  ////////////////////
  // Next state

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (cmd_upd && burst_rd_i) state_d = RBEGIN;
        else if (cmd_upd && burst_wr_i) state_d = WREADY;
      end
      RBEGIN:  state_d = word_zero ? IDLE : RREADY;  // Zero count burst is dropped
      RREADY:  if (module_select_i && capture_dr_i) state_d = RSTATUS;
      RSTATUS: if (biu_rdy_i) state_d = RBURST;    // Bus stalls here
      RBURST:  if (bit_max && word_zero) state_d = RCRC;
      WREADY: begin
        if (word_zero) state_d = IDLE;
        else if (module_select_i && capture_dr_i) state_d = WWAIT;
      end
      WWAIT:   if (module_select_i && data_register_i[DR_LEN-1]) state_d = WBURST;  // Start bit
      WBURST:  if (bit_max && word_zero) state_d = WCRC;
      WCRC:    if (bit_32) state_d = WMATCH;
      default: state_d = state_q;  // RCRC and WMATCH hold until update
    endcase
    if (state_q != IDLE && update_dr_i) state_d = IDLE;  // Host ends or aborts burst
  end

  ////////////////////
  // Control outputs

  always_comb begin
    ctrl_o         = '0;
    ctrl_o.tdo_sel = DATA;
    {addr_ld, addr_inc, bit_clr, bit_inc, word_ld, word_dec} = '0;
    {op_ld_o, strb, clr_err, load_word, inhibit_o} = '0;
    case (state_q)
      IDLE: begin
        ctrl_o.out_shift = module_select_i & shift_dr_i;   // Error register read-out
        ctrl_o.out_ld    = module_select_i & capture_dr_i;
        ctrl_o.ireg_clr  = cmd_upd & ireg_wr_i & data_register_i.cmd.addr[ADDR_WIDTH-1];
        if (state_d != IDLE) begin
          {addr_ld, op_ld_o, bit_clr, word_ld} = '1;
          ctrl_o.crc_clr = 1'b1;
        end
      end
      RBEGIN: {strb, addr_inc} = {2{~word_zero}};  // First read goes out early
      RSTATUS: begin
        ctrl_o.tdo_sel = READY;
        inhibit_o      = 1'b1;
        load_word      = (state_d == RBURST);
      end
      RBURST: begin
        {ctrl_o.out_shift, ctrl_o.crc_en, bit_inc, inhibit_o} = '1;
        bit_clr   = bit_max;
        load_word = bit_max & ~word_zero;
      end
      RCRC: begin
        ctrl_o.tdo_sel   = CRC;
        ctrl_o.crc_shift = 1'b1;
        inhibit_o        = 1'b1;
      end
      WWAIT: begin
        inhibit_o = 1'b1;
        if (state_d == WBURST) begin
          // TDI already holds data bit 0 here
          {clr_err, bit_inc, word_dec, ctrl_o.crc_en, ctrl_o.crc_in_tdi} = '1;
        end
      end
      WBURST: begin
        {bit_inc, ctrl_o.crc_en, ctrl_o.crc_in_tdi, inhibit_o} = '1;
        if (bit_max) begin  // Last bit of word on TDI
          {ctrl_o.err_chk, bit_clr, strb, addr_inc} = '1;
          word_dec = ~word_zero;
        end
      end
      WCRC: begin
        bit_inc   = 1'b1;
        inhibit_o = 1'b1;
        if (bit_32) ctrl_o.tdo_sel = MATCH;
      end
      WMATCH: begin
        ctrl_o.tdo_sel = MATCH;
        inhibit_o      = 1'b1;
        ctrl_o.err_chk = update_dr_i & crc_match_i;  // Final write status, good bursts only
      end
      default: ;  // RREADY and WREADY just wait
    endcase
    if (load_word) begin
      {ctrl_o.err_chk, ctrl_o.out_ld, ctrl_o.out_ld_bus, word_dec} = '1;
      {strb, addr_inc} = {2{more_words}};
      bit_clr = 1'b1;
    end
  end

  ////////////////////
  // Counters

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      state_q    <= IDLE;
      addr_q     <= '0;
      bit_cnt_q  <= '0;
      word_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (addr_ld) addr_q <= data_register_i.cmd.addr;
      else if (addr_inc) addr_q <= addr_q + ADDR_WIDTH'(cfg_i.size_bytes);
      if (bit_clr) bit_cnt_q <= '0;
      else if (bit_inc) bit_cnt_q <= bit_cnt_q + 6'd1;
      if (word_ld) word_cnt_q <= data_register_i.cmd.count;
      else if (word_dec) word_cnt_q <= word_cnt_q - 16'd1;
    end
  end

  // Write word is the newest W bits, left aligned
  assign bus_req_o.addr       = addr_q;
  assign bus_req_o.wdata      = {dbg_tdi_i, data_register_i[DR_LEN-1 -: DATA_WIDTH-1]};
  assign bus_req_o.rd         = cfg_i.rd;
  assign bus_req_o.size_bytes = cfg_i.size_bytes;
  assign bus_req_o.strb       = strb;
  assign bus_req_o.clr_err    = clr_err | ctrl_o.ireg_clr;  // Also drop bus error on clear

endmodule

//--- design/dbg_bus_module.sv
/*
  JTAG debug bus module
  Burst access from the TAP data register to a simple 32-bit bus.
  Chain of command decode, burst control and serial data path
*/
`timescale 1ns/100ps

module dbg_bus_module #(
  parameter int DR_LEN     = dbg_bus_pkg::DR_LEN,
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32
) (
  input  logic                  dbg_clk,
  input  logic                  dbg_rst,
  input  logic                  dbg_tdi_i,
  output logic                  dbg_tdo_o,
  input  logic                  capture_dr_i,  // TAP strobes
  input  logic                  shift_dr_i,
  input  logic                  update_dr_i,
  input  dbg_bus_pkg::dbg_dr_u  data_register_i,
  input  logic                  module_select_i,
  output logic                  inhibit_o,
  output dbg_bus_pkg::bus_req_t bus_req_o,
  input  logic [DATA_WIDTH-1:0] biu_rdata_i,
  input  logic                  biu_rdy_i,
  input  logic                  biu_err_i
);
  import dbg_bus_pkg::*;

  logic      burst_rd;
  logic      burst_wr;
  logic      ireg_wr;
  logic      module_cmd;
  logic      op_ld;
  logic      crc_match;
  word_cfg_t cfg;
  tdo_ctrl_t ctrl;

  dbg_cmd_decode u_decode (
    .dbg_clk(dbg_clk), .data_register_i(data_register_i), .op_ld_i(op_ld),
    .burst_rd_o(burst_rd), .burst_wr_o(burst_wr), .ireg_wr_o(ireg_wr),
    .module_cmd_o(module_cmd), .cfg_o(cfg)
  );

  dbg_burst_ctrl #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH), .DR_LEN(DR_LEN)) u_ctrl (
    .dbg_clk(dbg_clk), .dbg_rst(dbg_rst), .dbg_tdi_i(dbg_tdi_i),
    .capture_dr_i(capture_dr_i), .shift_dr_i(shift_dr_i), .update_dr_i(update_dr_i),
    .module_select_i(module_select_i), .data_register_i(data_register_i),
    .burst_rd_i(burst_rd), .burst_wr_i(burst_wr), .ireg_wr_i(ireg_wr),
    .module_cmd_i(module_cmd), .cfg_i(cfg), .biu_rdy_i(biu_rdy_i), .crc_match_i(crc_match),
    .op_ld_o(op_ld), .ctrl_o(ctrl), .bus_req_o(bus_req_o), .inhibit_o(inhibit_o)
  );

  dbg_tdo_path #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) u_tdo (
    .dbg_clk(dbg_clk), .dbg_rst(dbg_rst), .dbg_tdi_i(dbg_tdi_i), .ctrl_i(ctrl),
    .data_register_i(data_register_i), .biu_rdata_i(biu_rdata_i), .biu_rdy_i(biu_rdy_i),
    .biu_err_i(biu_err_i), .bus_req_i(bus_req_o),
    .dbg_tdo_o(dbg_tdo_o), .crc_match_o(crc_match)
  );

endmodule

//--- design/dbg_bus_pkg.sv
/*
  Debug bus unit shared definitions
  Burst opcodes, burst FSM states, TDO source select, the two views of
  the TAP data register, and the structs passed between the stages
*/
package dbg_bus_pkg;

  localparam int DR_LEN = 64;  // TAP data register length

  // Opcodes carried in the command word, other codes are ignored
  typedef enum logic [3:0] {
    BWRITE8  = 4'h1,
    BWRITE16 = 4'h2,
    BWRITE32 = 4'h3,
    BREAD8   = 4'h5,
    BREAD16  = 4'h6,
    BREAD32  = 4'h7,
    IREG_WR  = 4'h9
  } bus_op_e;

  // Burst FSM, read branch then write branch
  typedef enum logic [3:0] {
    IDLE    = 4'b1011,
    RBEGIN  = 4'b1010,
    RREADY  = 4'b1001,
    RSTATUS = 4'b1000,
    RBURST  = 4'b0111,
    RCRC    = 4'b0010,
    WREADY  = 4'b0110,
    WWAIT   = 4'b0101,
    WBURST  = 4'b0100,
    WCRC    = 4'b0001,
    WMATCH  = 4'b0000
  } burst_state_e;

  typedef enum logic [1:0] {
    READY = 2'd0,  // Bus ready level
    DATA  = 2'd1,  // Output shift register LSB
    MATCH = 2'd2,  // CRC compare result
    CRC   = 2'd3   // CRC serial out
  } tdo_sel_e;

  ////////////////////
  // Data register views

  typedef struct packed {
    logic        top_cmd;  // 0 selects this module
    bus_op_e     opcode;
    logic [31:0] addr;     // Bit 31 doubles as clear flag for IREG_WR
    logic [15:0] count;    // Words in burst
    logic [10:0] spare;
  } dr_cmd_t;

  typedef struct packed {
    logic [31:0] last32;  // Newest serial bit at the top
    logic [31:0] low32;
  } dr_stream_t;

  typedef union packed {
    dr_cmd_t    cmd;
    dr_stream_t stream;
  } dbg_dr_u;

  ////////////////////
  // Stage to stage structs

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        rd;
    logic [3:0]  size_bytes;
    logic        strb;     // One cycle launch
    logic        clr_err;  // One cycle bus error clear
  } bus_req_t;

  typedef struct packed {
    logic [5:0] size_bits_m1;  // Word size in bits minus one
    logic [3:0] size_bytes;
    logic       rd;
  } word_cfg_t;

  typedef struct packed {
    logic     out_ld;      // Parallel load of output register
    logic     out_ld_bus;  // Load source, 1 = bus read data, 0 = error register
    logic     out_shift;
    logic     crc_clr;
    logic     crc_en;
    logic     crc_in_tdi;  // CRC input, 1 = TDI, 0 = output register LSB
    logic     crc_shift;
    logic     err_chk;     // Sample bus error and ready
    logic     ireg_clr;    // Clear the error bit
    tdo_sel_e tdo_sel;
  } tdo_ctrl_t;

endpackage

//--- design/dbg_cmd_decode.sv
/*
  Command decoder
  Decodes the opcode of the command word held in the TAP data register
  and latches word size and direction when a burst is accepted
*/
`timescale 1ns/100ps

module dbg_cmd_decode (
  input  logic                   dbg_clk,
  input  dbg_bus_pkg::dbg_dr_u   data_register_i,
  input  logic                   op_ld_i,
  output logic                   burst_rd_o,
  output logic                   burst_wr_o,
  output logic                   ireg_wr_o,
  output logic                   module_cmd_o,
  output dbg_bus_pkg::word_cfg_t cfg_o
);
  import dbg_bus_pkg::*;

  bus_op_e   op;
  word_cfg_t cfg_d;

  assign op           = data_register_i.cmd.opcode;
  assign module_cmd_o = ~data_register_i.cmd.top_cmd;  // Top bit low means ours
  assign burst_wr_o   = op inside {BWRITE8, BWRITE16, BWRITE32};
  assign burst_rd_o   = op inside {BREAD8, BREAD16, BREAD32};
  assign ireg_wr_o    = (op == IREG_WR);

  // Size lookup, bit count kept as bits-1 for the counter compare
  always_comb begin
    cfg_d = '0;
    case (op)
      BWRITE8, BREAD8: begin
        cfg_d.size_bits_m1 = 6'd7;
        cfg_d.size_bytes   = 4'd1;
      end
      BWRITE16, BREAD16: begin
        cfg_d.size_bits_m1 = 6'd15;
        cfg_d.size_bytes   = 4'd2;
      end
      default: begin  // 32-bit words
        cfg_d.size_bits_m1 = 6'd31;
        cfg_d.size_bytes   = 4'd4;
      end
    endcase
    cfg_d.rd = burst_rd_o;
  end

  // Held for the whole burst
  always_ff @(posedge dbg_clk) begin
    if (op_ld_i) begin
      cfg_o <= cfg_d;
    end
  end

endmodule

//--- design/dbg_crc32.sv
/*
  Bit-serial CRC-32
  Reflected polynomial EDB88320, preset to all ones, no final inversion.
  Shifting turns the register into its own serial output
*/
`timescale 1ns/100ps

module dbg_crc32 (
  input  logic        dbg_clk,
  input  logic        dbg_rst,
  input  logic        data_i,
  input  logic        en_i,
  input  logic        shift_i,
  input  logic        clr_i,
  output logic [31:0] crc_o,
  output logic        serial_o
);

  localparam logic [31:0] POLY = 32'hEDB88320;

  logic fb;  // Feedback bit

  assign fb       = crc_o[0] ^ data_i;
  assign serial_o = crc_o[0];  // LSB leaves first

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      crc_o <= '1;
    end else if (clr_i) begin
      crc_o <= '1;  // Preset for a new burst
    end else if (en_i) begin
      crc_o <= {1'b0, crc_o[31:1]} ^ ({32{fb}} & POLY);
    end else if (shift_i) begin
      crc_o <= {1'b0, crc_o[31:1]};  // Plain shift for read-out
    end
  end

endmodule

//--- design/dbg_tdo_path.sv
/*
  Serial data path
  Output shift register, bus error register, CRC engine and TDO select.
  The error register tracks each launched address until a transfer fails
*/
`timescale 1ns/100ps

module dbg_tdo_path #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32
) (
  input  logic                   dbg_clk,
  input  logic                   dbg_rst,
  input  logic                   dbg_tdi_i,
  input  dbg_bus_pkg::tdo_ctrl_t ctrl_i,
  input  dbg_bus_pkg::dbg_dr_u   data_register_i,
  input  logic [DATA_WIDTH-1:0]  biu_rdata_i,
  input  logic                   biu_rdy_i,
  input  logic                   biu_err_i,
  input  dbg_bus_pkg::bus_req_t  bus_req_i,
  output logic                   dbg_tdo_o,
  output logic                   crc_match_o
);
  import dbg_bus_pkg::*;

  logic [DATA_WIDTH:0] out_sr_q;  // 33 bits to hold the error register
  logic [ADDR_WIDTH:0] err_q;     // Address on top, error flag in bit 0
  logic [31:0]         crc;
  logic                crc_din;
  logic                crc_serial;

  // First failure freezes the address until cleared
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      err_q <= '0;
    end else if (ctrl_i.ireg_clr) begin
      err_q[0] <= 1'b0;
    end else if (!err_q[0]) begin
      if (ctrl_i.err_chk && (biu_err_i || !biu_rdy_i)) begin
        err_q[0] <= 1'b1;  // Error or ready still low
      end else if (bus_req_i.strb) begin
        err_q[ADDR_WIDTH:1] <= bus_req_i.addr;
      end
    end
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      out_sr_q <= '0;
    end else if (ctrl_i.out_ld) begin
      out_sr_q <= ctrl_i.out_ld_bus ? {1'b0, biu_rdata_i} : err_q;
    end else if (ctrl_i.out_shift) begin
      out_sr_q <= {1'b0, out_sr_q[DATA_WIDTH:1]};  // LSB first
    end
  end

  assign crc_din = ctrl_i.crc_in_tdi ? dbg_tdi_i : out_sr_q[0];  // Write vs read data

  dbg_crc32 u_crc (
    .dbg_clk (dbg_clk),
    .dbg_rst (dbg_rst),
    .data_i  (crc_din),
    .en_i    (ctrl_i.crc_en),
    .shift_i (ctrl_i.crc_shift),
    .clr_i   (ctrl_i.crc_clr),
    .crc_o   (crc),
    .serial_o(crc_serial)
  );

  assign crc_match_o = (data_register_i.stream.last32 == crc);  // Host CRC now in top 32 bits

  always_comb begin
    case (ctrl_i.tdo_sel)
      READY:   dbg_tdo_o = biu_rdy_i;
      DATA:    dbg_tdo_o = out_sr_q[0];
      MATCH:   dbg_tdo_o = crc_match_o;
      default: dbg_tdo_o = crc_serial;
    endcase
  end

endmodule

//--- sources.f
design/dbg_bus_pkg.sv
design/dbg_cmd_decode.sv
design/dbg_burst_ctrl.sv
design/dbg_crc32.sv
design/dbg_tdo_path.sv
design/dbg_bus_module.sv
verif/dbg_bus_module_tb.sv

//--- verif/dbg_bus_module_tb.sv
/*
  Debug bus module testbench
  Models the TAP data register and a 256-byte bus memory, then runs
  directed burst write, burst read, bus error and zero count tests
*/
`timescale 1ns/100ps

module dbg_bus_module_tb;
  import dbg_bus_pkg::*;

  localparam int          MAX_CYCLES = 20000;         // Tests need under 2000 cycles
  localparam logic [31:0] ERR_ADDR   = 32'h0000_0040; // Bus faults on this address
  localparam logic [31:0] POLY       = 32'hEDB88320;

  logic        dbg_clk;
  logic        dbg_rst;
  logic        dbg_tdi_i;
  logic        dbg_tdo_o;
  logic        capture_dr_i;
  logic        shift_dr_i;
  logic        update_dr_i;
  logic        module_select_i;
  logic        inhibit_o;
  logic [63:0] dr;           // Host side data register
  bus_req_t    bus_req_o;
  bus_req_t    req_s;        // Request sampled mid cycle
  logic [31:0] biu_rdata_i;
  logic        biu_rdy_i;
  logic        biu_err_i;
  logic [7:0]  mem [256];
  logic [31:0] wr_words [4];
  logic [31:0] strb_addr_q [$];
  logic [31:0] strb_data_q [$];
  logic        strb_rd_q [$];
  logic [3:0]  strb_size_q [$];
  int          busy;
  int          errors;
  int          checks;
  int          cycles;

  dbg_bus_module #(.DR_LEN(DR_LEN), .ADDR_WIDTH(32), .DATA_WIDTH(32)) UUT (
    .dbg_clk(dbg_clk), .dbg_rst(dbg_rst), .dbg_tdi_i(dbg_tdi_i), .dbg_tdo_o(dbg_tdo_o),
    .capture_dr_i(capture_dr_i), .shift_dr_i(shift_dr_i), .update_dr_i(update_dr_i),
    .data_register_i(dr), .module_select_i(module_select_i), .inhibit_o(inhibit_o),
    .bus_req_o(bus_req_o), .biu_rdata_i(biu_rdata_i), .biu_rdy_i(biu_rdy_i),
    .biu_err_i(biu_err_i)
  );

  always #20 dbg_clk = ~dbg_clk;

  // Run limit
  always @(posedge dbg_clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  ////////////////////
  // Bus memory model

  always @(negedge dbg_clk) req_s = bus_req_o;  // Stable between edges

  always @(posedge dbg_clk) begin
    logic [7:0] a;
    int         nb;
    #2;
    a  = req_s.addr[7:0];
    nb = int'(req_s.size_bytes);
    if (busy > 0) begin
      busy      = busy - 1;
      biu_rdy_i = (busy == 0);
    end
    if (req_s.clr_err) biu_err_i = 1'b0;
    if (req_s.strb) begin
      strb_addr_q.push_back(req_s.addr);
      strb_data_q.push_back(req_s.wdata);
      strb_rd_q.push_back(req_s.rd);
      strb_size_q.push_back(req_s.size_bytes);
      if (req_s.rd) begin
        biu_rdata_i = {mem[a + 8'd3], mem[a + 8'd2], mem[a + 8'd1], mem[a]};
      end else begin
        for (int i = 0; i < nb; i++) begin
          mem[a + 8'(i)] = req_s.wdata[32 - nb * 8 + i * 8 +: 8];  // Left aligned word
        end
      end
      biu_err_i = (req_s.addr == ERR_ADDR);
      busy      = int'($urandom % 4);
      biu_rdy_i = (busy == 0);
    end
  end

  ////////////////////
  // Helpers

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks = checks + 1;
    assert (act === exp) else begin
      errors = errors + 1;
      $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic report_fail(input string what);
    errors = errors + 1;
    $display("Failure at %0t: %s", $time, what);
  endtask

  // Reflected CRC-32, one bit
  function automatic logic [31:0] crc_step(input logic [31:0] c, input logic b);
    return (c >> 1) ^ ((c[0] ^ b) ? POLY : 32'h0);
  endfunction

  function automatic logic [63:0] make_cmd(input bus_op_e op, input logic [31:0] addr,
                                           input logic [15:0] cnt);
    return {1'b0, op, addr, cnt, 11'h0};
  endfunction

  task automatic tick();
    @(posedge dbg_clk);
    #2;
  endtask

  // One TAP shift, TDO taken at mid cycle
  task automatic shift_bit(input logic b, output logic tdo);
    dbg_tdi_i  = b;
    shift_dr_i = 1'b1;
    @(negedge dbg_clk);
    tdo = dbg_tdo_o;
    tick();
    dr         = {b, dr[63:1]};
    shift_dr_i = 1'b0;
    dbg_tdi_i  = 1'b0;
  endtask

  task automatic issue_cmd(input logic [63:0] cmd);
    dr          = cmd;
    update_dr_i = 1'b1;
    tick();
    update_dr_i = 1'b0;
  endtask

  task automatic capture();
    dr           = '0;
    capture_dr_i = 1'b1;
    tick();
    capture_dr_i = 1'b0;
  endtask

  task automatic end_burst();
    update_dr_i = 1'b1;
    tick();
    update_dr_i = 1'b0;
  endtask

  task automatic clear_log();
    strb_addr_q.delete();
    strb_data_q.delete();
    strb_rd_q.delete();
    strb_size_q.delete();
  endtask

  ////////////////////
  // Burst tasks

  task automatic write_burst32(input logic [31:0] addr, input logic flip, output logic match);
    logic [31:0] crc;
    logic        t;
    crc = '1;
    clear_log();
    issue_cmd(make_cmd(BWRITE32, addr, 16'd4));
    capture();
    shift_bit(1'b1, t);  // Start bit
    for (int k = 0; k < 4; k++) begin
      for (int i = 0; i < 32; i++) begin
        crc = crc_step(crc, wr_words[k][i]);
        shift_bit(wr_words[k][i], t);
      end
    end
    if (flip) crc[5] = ~crc[5];
    for (int i = 0; i < 32; i++) shift_bit(crc[i], t);
    @(negedge dbg_clk);  // Match bit, register left untouched
    match = dbg_tdo_o;
    tick();
    end_burst();
    check_val("strb count", 64'd4, 64'(strb_addr_q.size()));
    for (int k = 0; k < 4 && k < strb_addr_q.size(); k++) begin
      check_val("bus_req_o.addr", 64'(addr + 32'(4 * k)), 64'(strb_addr_q[k]));
      check_val("bus_req_o.wdata", 64'(wr_words[k]), 64'(strb_data_q[k]));
      check_val("bus_req_o.rd", 64'd0, 64'(strb_rd_q[k]));
      check_val("bus_req_o.size_bytes", 64'd4, 64'(strb_size_q[k]));
    end
  endtask

  task automatic read_burst(input bus_op_e op, input logic [31:0] addr, input int cnt);
    int          nb;
    int          polls;
    logic        t;
    logic [31:0] crc;
    logic [31:0] got;
    logic [31:0] exp_w;
    logic [7:0]  a;
    nb  = (op == BREAD8) ? 1 : (op == BREAD16) ? 2 : 4;
    crc = '1;
    t   = 1'b0;
    clear_log();
    issue_cmd(make_cmd(op, addr, 16'(cnt)));
    tick();  // First read launches here
    capture();
    polls = 0;
    while (!t && polls < 16) begin
      shift_bit(1'b0, t);
      polls++;
    end
    if (!t) report_fail("ready bit never showed on TDO");
    for (int k = 0; k < cnt; k++) begin
      exp_w = '0;
      got   = '0;
      for (int b = 0; b < nb; b++) begin
        a = addr[7:0] + 8'(k * nb + b);
        exp_w[8 * b +: 8] = mem[a];
      end
      for (int i = 0; i < nb * 8; i++) begin
        shift_bit(1'b0, t);
        got[i] = t;
        crc    = crc_step(crc, exp_w[i]);
      end
      check_val("dbg_tdo_o read word", 64'(exp_w), 64'(got));
    end
    for (int i = 0; i < 32; i++) begin
      shift_bit(1'b0, t);
      got[i] = t;
    end
    check_val("dbg_tdo_o crc", 64'(crc), 64'(got));
    check_val("inhibit_o", 64'd1, 64'(inhibit_o));  // Still in CRC read-out
    end_burst();
    check_val("inhibit_o", 64'd0, 64'(inhibit_o));
    check_val("strb count", 64'(cnt), 64'(strb_addr_q.size()));
    for (int k = 0; k < cnt && k < strb_addr_q.size(); k++) begin
      check_val("bus_req_o.addr", 64'(addr + 32'(k * nb)), 64'(strb_addr_q[k]));
      check_val("bus_req_o.rd", 64'd1, 64'(strb_rd_q[k]));
      check_val("bus_req_o.size_bytes", 64'(nb), 64'(strb_size_q[k]));
    end
  endtask

  task automatic read_err_reg(output logic [32:0] val);
    logic t;
    capture();
    for (int i = 0; i < 33; i++) begin
      shift_bit(1'b0, t);
      val[i] = t;
    end
  endtask

  ////////////////////
  // Test sequence

  initial begin
    logic        match;
    logic [32:0] e;
    void'($urandom(32'h1455e512));
    {dbg_clk, dbg_tdi_i, capture_dr_i, shift_dr_i, update_dr_i, biu_err_i} = '0;
    dbg_rst         = 1'b1;
    module_select_i = 1'b1;
    biu_rdy_i       = 1'b1;
    biu_rdata_i     = '0;
    req_s           = '0;
    dr              = '0;
    {busy, errors, checks, cycles} = '0;
    for (int i = 0; i < 256; i++) mem[i] = 8'((i * 29) ^ (i >> 3) ^ 8'h6b);
    repeat (16) @(posedge dbg_clk);
    #2;
    dbg_rst = 1'b0;

    // Reset values
    check_val("dbg_tdo_o", 64'd0, 64'(dbg_tdo_o));
    check_val("inhibit_o", 64'd0, 64'(inhibit_o));
    check_val("bus_req_o.strb", 64'd0, 64'(bus_req_o.strb));
    check_val("bus_req_o.clr_err", 64'd0, 64'(bus_req_o.clr_err));

    // Write with good CRC, then with one bad CRC bit
    for (int k = 0; k < 4; k++) wr_words[k] = $urandom;
    write_burst32(32'h80, 1'b0, match);
    check_val("crc match", 64'd1, 64'(match));
    for (int k = 0; k < 16; k++) begin
      check_val("memory byte", 64'(wr_words[k / 4][8 * (k % 4) +: 8]), 64'(mem[8'h80 + 8'(k)]));
    end
    write_burst32(32'h80, 1'b1, match);
    check_val("crc match", 64'd0, 64'(match));

    read_burst(BREAD8, 32'h10, 5);
    read_burst(BREAD16, 32'h20, 3);

    // Error trap and clear
    read_burst(BREAD8, 32'h3E, 4);
    read_err_reg(e);
    check_val("error register", 64'({ERR_ADDR, 1'b1}), 64'(e));
    issue_cmd(make_cmd(IREG_WR, 32'h8000_0000, 16'd0));
    read_err_reg(e);
    check_val("error flag", 64'd0, 64'(e[0]));

    // Zero count burst
    clear_log();
    issue_cmd(make_cmd(BREAD8, 32'h50, 16'd0));
    repeat (4) tick();
    check_val("strb count", 64'd0, 64'(strb_addr_q.size()));
    read_burst(BREAD32, 32'h80, 2);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
